// ==== hdl/mmio_config.svh ====
`ifndef MMIO_CONFIG_SVH
`define MMIO_CONFIG_SVH

// upper halfword of the GPIO register window
`define MMIO_GPIO_BASE 16'hF000

// upper halfword of the text cell window
`define MMIO_TEXT_BASE 16'hF001

// number of GPIO pins
`define GPIO_WIDTH 16

// text cells, one 32-bit word each
`define TEXT_DEPTH 256

`endif

// ==== hdl/mmioPkg.sv ====
package mmioPkg;

	typedef enum logic
	{
		opRead  = 1'b0,
		opWrite = 1'b1
	} mmioOp;

	typedef enum logic
	{
		stOk    = 1'b0,
		stFault = 1'b1
	} mmioStatus;

	typedef enum logic [1:0]
	{
		selGpio = 2'd0,
		selText = 2'd1,
		selNone = 2'd2
	} devSel;

	// request as seen on the router side
	typedef struct packed
	{
		logic [31:0] addr;
		mmioOp       op;
		logic [31:0] wdata;
	} mmioReq;

	typedef struct packed
	{
		logic [31:0] rdata;
		mmioStatus   status;
	} mmioResp;

	// decoded access, stage 1 output and device input
	typedef struct packed
	{
		logic        valid;
		devSel       sel;
		logic [15:0] offset;
		mmioOp       op;
		logic [31:0] wdata;
	} devAccess;

	// per-device result, stage 2 output
	typedef struct packed
	{
		logic        valid;
		logic [31:0] rdata;
		mmioStatus   status;
	} devResult;

endpackage

// ==== hdl/mmioDecode.sv ====
`timescale 1ns/1ps

`include "mmio_config.svh"

module mmioDecode
(
	input  logic              clock,
	input  logic              rst,
	input  logic              advance,
	input  logic              reqValid,
	input  mmioPkg::mmioReq   req,
	output mmioPkg::devAccess access
);

	mmioPkg::devSel    selNext;
	mmioPkg::devAccess accessNext;

	// region compare on the upper address halfword
	always_comb
	begin
		if (req.addr[31:16] == `MMIO_GPIO_BASE)
		begin
			selNext = mmioPkg::selGpio;
		end
		else if (req.addr[31:16] == `MMIO_TEXT_BASE)
		begin
			selNext = mmioPkg::selText;
		end
		else
		begin
			selNext = mmioPkg::selNone;
		end
	end

	always_comb
	begin
		accessNext.valid  = reqValid;
		accessNext.sel    = selNext;
		// byte lanes are ignored, offsets are word aligned
		accessNext.offset = {req.addr[15:2], 2'b00};
		accessNext.op     = req.op;
		accessNext.wdata  = req.wdata;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			access.valid <= 1'b0;
		end
		else if (advance)
		begin
			access <= accessNext;
		end
	end

endmodule

// ==== hdl/gpioRegs.sv ====
`timescale 1ns/1ps

`include "mmio_config.svh"

module gpioRegs
(
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   advance,
	input  mmioPkg::devAccess      access,
	input  logic [`GPIO_WIDTH-1:0] gpioIn,
	output logic [`GPIO_WIDTH-1:0] gpioOut,
	output logic [`GPIO_WIDTH-1:0] gpioDir,
	output mmioPkg::devResult      result
);

	logic hit;
	logic isWrite;
	logic fault;
	logic [31:0] readData;

	assign hit     = access.valid && (access.sel == mmioPkg::selGpio);
	assign isWrite = (access.op == mmioPkg::opWrite);

	// register map: 0 out, 4 dir, 8 input pins (read only)
	always_comb
	begin
		fault    = 1'b0;
		readData = '0;
		case (access.offset)
			16'h0000: readData = 32'(gpioOut);
			16'h0004: readData = 32'(gpioDir);
			16'h0008:
			begin
				readData = 32'(gpioIn);
				fault    = isWrite;
			end
			default:  fault = 1'b1;
		endcase
		// writes and faults return zero data
		if (isWrite || fault)
		begin
			readData = '0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			gpioOut      <= '0;
			gpioDir      <= '0;
			result.valid <= 1'b0;
		end
		else if (advance)
		begin
			result.valid  <= hit;
			result.rdata  <= readData;
			result.status <= fault ? mmioPkg::stFault : mmioPkg::stOk;
			if (hit && isWrite && !fault && access.offset == 16'h0000)
			begin
				gpioOut <= access.wdata[`GPIO_WIDTH-1:0];
			end
			if (hit && isWrite && !fault && access.offset == 16'h0004)
			begin
				gpioDir <= access.wdata[`GPIO_WIDTH-1:0];
			end
		end
	end

endmodule

// ==== hdl/textRegs.sv ====
`timescale 1ns/1ps

`include "mmio_config.svh"

module textRegs
(
	input  logic              clock,
	input  logic              rst,
	input  logic              advance,
	input  mmioPkg::devAccess access,
	output mmioPkg::devResult result
);

	localparam int IDX_W = $clog2(`TEXT_DEPTH);

	logic [31:0] cells [`TEXT_DEPTH];

	logic             hit;
	logic             isWrite;
	logic             inRange;
	logic [IDX_W-1:0] cellIdx;

	assign hit     = access.valid && (access.sel == mmioPkg::selText);
	assign isWrite = (access.op == mmioPkg::opWrite);

	// word index, checked against the full offset so aliases fault
	assign inRange = {18'd0, access.offset[15:2]} < `TEXT_DEPTH;
	assign cellIdx = access.offset[IDX_W+1:2];

	// cell storage, written only on an advancing edge
	always_ff @(posedge clock)
	begin
		if (advance && hit && isWrite && inRange)
		begin
			cells[cellIdx] <= access.wdata;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			result.valid <= 1'b0;
		end
		else if (advance)
		begin
			result.valid  <= hit;
			result.status <= inRange ? mmioPkg::stOk : mmioPkg::stFault;
			if (inRange && !isWrite)
			begin
				result.rdata <= cells[cellIdx];
			end
			else
			begin
				result.rdata <= '0;
			end
		end
	end

endmodule

// ==== hdl/mmioRespMerge.sv ====
`timescale 1ns/1ps

module mmioRespMerge
(
	input  logic              clock,
	input  logic              rst,
	input  mmioPkg::devAccess access,
	input  mmioPkg::devResult gpioResult,
	input  mmioPkg::devResult textResult,
	input  logic              respReady,
	output logic              respValid,
	output mmioPkg::mmioResp  resp,
	output logic              advance
);

	logic noneValid;
	mmioPkg::mmioResp respNext;

	// pipeline moves when the output slot is free or being drained
	assign advance = !respValid || respReady;

	// unmapped marker, aligned with the device stage
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			noneValid <= 1'b0;
		end
		else if (advance)
		begin
			noneValid <= access.valid && (access.sel == mmioPkg::selNone);
		end
	end

	// at most one of the three sources is valid at a time
	always_comb
	begin
		respNext.rdata  = '0;
		respNext.status = mmioPkg::stFault;
		if (gpioResult.valid)
		begin
			respNext.rdata  = gpioResult.rdata;
			respNext.status = gpioResult.status;
		end
		else if (textResult.valid)
		begin
			respNext.rdata  = textResult.rdata;
			respNext.status = textResult.status;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			respValid <= 1'b0;
		end
		else if (advance)
		begin
			respValid <= gpioResult.valid || textResult.valid || noneValid;
			resp      <= respNext;
		end
	end

endmodule

// ==== hdl/mmioTop.sv ====
`timescale 1ns/1ps

`include "mmio_config.svh"

module mmioTop
(
	input  logic                   clock,
	input  logic                   rst,
	input  logic                   reqValid,
	output logic                   reqReady,
	input  mmioPkg::mmioReq        req,
	output logic                   respValid,
	input  logic                   respReady,
	output mmioPkg::mmioResp       resp,
	input  logic [`GPIO_WIDTH-1:0] gpioIn,
	output logic [`GPIO_WIDTH-1:0] gpioOut,
	output logic [`GPIO_WIDTH-1:0] gpioDir
);

	mmioPkg::devAccess access;
	mmioPkg::devResult gpioResult;
	mmioPkg::devResult textResult;

	// reqReady doubles as the shared advance enable
	mmioDecode decode
	(
		.clock    (clock),
		.rst      (rst),
		.advance  (reqReady),
		.reqValid (reqValid),
		.req      (req),
		.access   (access)
	);

	gpioRegs gpio
	(
		.clock   (clock),
		.rst     (rst),
		.advance (reqReady),
		.access  (access),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioDir (gpioDir),
		.result  (gpioResult)
	);

	textRegs text
	(
		.clock   (clock),
		.rst     (rst),
		.advance (reqReady),
		.access  (access),
		.result  (textResult)
	);

	mmioRespMerge merge
	(
		.clock      (clock),
		.rst        (rst),
		.access     (access),
		.gpioResult (gpioResult),
		.textResult (textResult),
		.respReady  (respReady),
		.respValid  (respValid),
		.resp       (resp),
		.advance    (reqReady)
	);

endmodule

// ==== verif/mmio_props.sv ====
`timescale 1ns/1ps

module mmioProps
(
	input logic             clock,
	input logic             rst,
	input logic             reqValid,
	input logic             reqReady,
	input mmioPkg::mmioReq  req,
	input logic             respValid,
	input logic             respReady,
	input mmioPkg::mmioResp resp
);

	int errCount = 0;

	// requester holds the request while it waits
	reqHold: assert property (@(posedge clock) disable iff (rst)
		reqValid && !reqReady |=> reqValid && $stable(req))
		else
		begin
			errCount = errCount + 1;
			$error("req changed while stalled");
		end

	respHold: assert property (@(posedge clock) disable iff (rst)
		respValid && !respReady |=> respValid && $stable(resp))
		else
		begin
			errCount = errCount + 1;
			$error("resp changed while stalled");
		end

	// covers the reset cycles and the first cycle after
	resetIdle: assert property (@(posedge clock) rst |=> !respValid)
		else
		begin
			errCount = errCount + 1;
			$error("respValid high around reset");
		end

	readyWhenEmpty: assert property (@(posedge clock) disable iff (rst)
		!respValid |-> reqReady)
		else
		begin
			errCount = errCount + 1;
			$error("reqReady low with an empty response slot");
		end

endmodule

bind mmioTop mmioProps props (.*);

// ==== verif/mmioTb.sv ====
`timescale 1ns/1ps

`include "mmio_config.svh"

module mmioTb;

	localparam int LAT_N = 32;
	localparam int RAND_N = 400;
	// directed text and GPIO traffic plus the latency and random runs
	localparam int REQ_COUNT = 2 * `TEXT_DEPTH + 24 + LAT_N + RAND_N;

	logic clock;
	logic rst;
	logic reqValid;
	logic reqReady;
	mmioPkg::mmioReq req;
	logic respValid;
	logic respReady;
	mmioPkg::mmioResp resp;
	logic [`GPIO_WIDTH-1:0] gpioIn;
	logic [`GPIO_WIDTH-1:0] gpioOut;
	logic [`GPIO_WIDTH-1:0] gpioDir;

	logic [31:0] lfsr;
	logic readyRandom;
	logic gapsOn;
	logic latencyOn;
	int cycle;
	mmioPkg::mmioResp expQ [$];
	int acceptQ [$];
	logic [`GPIO_WIDTH-1:0] outModel;
	logic [`GPIO_WIDTH-1:0] dirModel;
	logic [31:0] textModel [`TEXT_DEPTH];

	mmioTop DUT (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		#(20 * REQ_COUNT * 10);
		abortRun("watchdog expired before the test sequence finished");
	end

	always @(negedge clock)
	begin
		if (DUT.props.errCount != 0)
		begin
			abortRun("a bound handshake or reset property failed");
		end
	end

	task automatic abortRun(input string why);
		$display("Test failures found");
		$fatal(1, "%s", why);
	endtask

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], nextBit()};
		end
		return v;
	endfunction

	task automatic checkResp(input mmioPkg::mmioResp exp, input mmioPkg::mmioResp act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t resp: expected %h/%0d got %h/%0d",
				$time, exp.rdata, exp.status, act.rdata, act.status);
			abortRun("response mismatch");
		end
	endtask

	task automatic checkPins(input logic [`GPIO_WIDTH-1:0] expOut,
		input logic [`GPIO_WIDTH-1:0] expDir);
		if (gpioOut !== expOut)
		begin
			$display("[FAIL] %0t gpioOut: expected %h got %h", $time, expOut, gpioOut);
			abortRun("gpioOut mismatch");
		end
		else if (gpioDir !== expDir)
		begin
			$display("[FAIL] %0t gpioDir: expected %h got %h", $time, expDir, gpioDir);
			abortRun("gpioDir mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s: expected %b got %b", $time, name, exp, act);
			abortRun("control flag mismatch");
		end
	endtask

	// reference behavior of the address map, updated in acceptance order
	task automatic applyModel(input mmioPkg::mmioReq r, output mmioPkg::mmioResp e);
		logic [15:0] off;
		logic [13:0] idx;
		logic isWr;
		off = {r.addr[15:2], 2'b00};
		idx = r.addr[15:2];
		isWr = (r.op == mmioPkg::opWrite);
		e.rdata = '0;
		e.status = mmioPkg::stOk;
		if (r.addr[31:16] == `MMIO_GPIO_BASE)
		begin
			if (isWr && off == 16'h0000)
				outModel = r.wdata[`GPIO_WIDTH-1:0];
			else if (isWr && off == 16'h0004)
				dirModel = r.wdata[`GPIO_WIDTH-1:0];
			else if (off == 16'h0000)
				e.rdata = 32'(outModel);
			else if (off == 16'h0004)
				e.rdata = 32'(dirModel);
			else if (off == 16'h0008 && !isWr)
				e.rdata = 32'(gpioIn);
			else
				e.status = mmioPkg::stFault;
		end
		else if (r.addr[31:16] == `MMIO_TEXT_BASE)
		begin
			if (idx >= `TEXT_DEPTH)
				e.status = mmioPkg::stFault;
			else if (isWr)
				textModel[idx] = r.wdata;
			else
				e.rdata = textModel[idx];
		end
		else
			e.status = mmioPkg::stFault;
	endtask

	// both handshakes are sampled at the rising edge while inputs move on the falling one
	always @(posedge clock)
	begin
		mmioPkg::mmioResp e;
		int acc;
		if (!rst)
		begin
			cycle = cycle + 1;
			if (respValid && respReady)
			begin
				if (expQ.size() == 0)
					abortRun("response arrived with no request outstanding");
				else
				begin
					e = expQ.pop_front();
					acc = acceptQ.pop_front();
					checkResp(e, resp);
					if (latencyOn && cycle - acc != 3)
					begin
						$display("[FAIL] %0t latency: expected 3 got %0d", $time, cycle - acc);
						abortRun("response latency wrong");
					end
				end
			end
			if (reqValid && reqReady)
			begin
				applyModel(req, e);
				expQ.push_back(e);
				acceptQ.push_back(cycle);
			end
		end
	end

	task automatic driveReady();
		if (readyRandom)
			respReady = (randBits(2) != 0);
		else
			respReady = 1'b1;
	endtask

	// called on a falling edge and returns on the falling edge after acceptance
	task automatic sendReq(input logic [31:0] addr, input mmioPkg::mmioOp op,
		input logic [31:0] wdata);
		logic done;
		done = 1'b0;
		req.addr = addr;
		req.op = op;
		req.wdata = wdata;
		reqValid = 1'b1;
		while (!done)
		begin
			@(posedge clock);
			done = reqReady;
			@(negedge clock);
			driveReady();
		end
		reqValid = 1'b0;
		while (gapsOn && randBits(2) == 0)
		begin
			@(negedge clock);
			driveReady();
		end
	endtask

	task automatic sendRandom();
		logic [1:0] region;
		logic [31:0] addr;
		mmioPkg::mmioOp op;
		region = 2'(randBits(2));
		if (region == 2'd0)
			addr = {`MMIO_GPIO_BASE, 12'd0, 2'(randBits(2)), 2'b00};
		else if (region == 2'd3)
			addr = {4'h2, 28'(randBits(28))};
		else
			// index up to twice the depth with random byte lanes
			addr = {`MMIO_TEXT_BASE, 5'd0, 11'(randBits(11))};
		op = nextBit() ? mmioPkg::opWrite : mmioPkg::opRead;
		sendReq(addr, op, randBits(32));
	endtask

	// wait for every outstanding response and then compare the pins
	task automatic drain();
		while (expQ.size() != 0)
		begin
			@(negedge clock);
			driveReady();
		end
		checkPins(outModel, dirModel);
	endtask

	initial
	begin
		lfsr = 32'd91655;
		rst = 1'b1;
		reqValid = 1'b0;
		req = '0;
		respReady = 1'b0;
		gpioIn = '0;
		readyRandom = 1'b0;
		gapsOn = 1'b0;
		latencyOn = 1'b0;
		cycle = 0;
		outModel = '0;
		dirModel = '0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		checkFlag("respValid", 1'b0, respValid);
		checkPins('0, '0);
		driveReady();

		// fill every text cell, read all back, then out-of-range cells
		for (int i = 0; i < `TEXT_DEPTH; i++)
		begin
			sendReq({`MMIO_TEXT_BASE, 14'(i), 2'b00}, mmioPkg::opWrite, randBits(32));
		end
		for (int i = 0; i < `TEXT_DEPTH; i++)
		begin
			sendReq({`MMIO_TEXT_BASE, 14'(i), 2'(randBits(2))}, mmioPkg::opRead, '0);
		end
		sendReq({`MMIO_TEXT_BASE, 14'(`TEXT_DEPTH), 2'b00}, mmioPkg::opWrite, randBits(32));
		sendReq({`MMIO_TEXT_BASE, 14'(`TEXT_DEPTH), 2'b00}, mmioPkg::opRead, '0);
		sendReq({`MMIO_TEXT_BASE, 14'h3fff, 2'b11}, mmioPkg::opRead, '0);
		drain();

		// GPIO registers, input snapshot and the read-only pin register
		sendReq({`MMIO_GPIO_BASE, 16'h0000}, mmioPkg::opWrite, randBits(32));
		sendReq({`MMIO_GPIO_BASE, 16'h0004}, mmioPkg::opWrite, randBits(32));
		drain();
		gpioIn = `GPIO_WIDTH'(randBits(`GPIO_WIDTH));
		sendReq({`MMIO_GPIO_BASE, 16'h0000}, mmioPkg::opRead, '0);
		sendReq({`MMIO_GPIO_BASE, 16'h0004}, mmioPkg::opRead, '0);
		sendReq({`MMIO_GPIO_BASE, 16'h0008}, mmioPkg::opRead, '0);
		sendReq({`MMIO_GPIO_BASE, 16'h0008}, mmioPkg::opWrite, randBits(32));
		sendReq({`MMIO_GPIO_BASE, 16'h000c}, mmioPkg::opRead, '0);
		drain();

		// unmapped regions, then confirm both devices are untouched
		for (int i = 0; i < 6; i++)
		begin
			sendReq({4'h2, 28'(randBits(28))}, mmioPkg::opWrite, randBits(32));
		end
		sendReq({`MMIO_GPIO_BASE, 16'h0000}, mmioPkg::opRead, '0);
		sendReq({`MMIO_TEXT_BASE, 16'h0000}, mmioPkg::opRead, '0);
		drain();

		// back-to-back traffic with the response side always ready
		latencyOn = 1'b1;
		for (int i = 0; i < LAT_N; i++)
		begin
			sendRandom();
		end
		drain();
		latencyOn = 1'b0;

		// random back-pressure and request gaps
		readyRandom = 1'b1;
		gapsOn = 1'b1;
		for (int i = 0; i < RAND_N; i++)
		begin
			if (i % 25 == 0)
			begin
				drain();
				gpioIn = `GPIO_WIDTH'(randBits(`GPIO_WIDTH));
			end
			sendRandom();
		end
		drain();

		if (DUT.props.errCount != 0)
		begin
			abortRun("a bound handshake or reset property failed");
		end
		else
		begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/mmioPkg.sv
hdl/mmioDecode.sv
hdl/gpioRegs.sv
hdl/textRegs.sv
hdl/mmioRespMerge.sv
hdl/mmioTop.sv
verif/mmio_props.sv
verif/mmioTb.sv

// ==== Bender.yml ====
package:
  name: mmio

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mmioPkg.sv
      - hdl/mmioDecode.sv
      - hdl/gpioRegs.sv
      - hdl/textRegs.sv
      - hdl/mmioRespMerge.sv
      - hdl/mmioTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/mmio_props.sv
      - verif/mmioTb.sv
